/* source/vp_config.svh */
//////////////////////////////
// Build constants shared by the machine glue core
// Include in any file that needs periods, widths or credits
//////////////////////////////
`ifndef VP_CONFIG_SVH
`define VP_CONFIG_SVH

// System clocks per CPU enable
`define VP_CPU_PERIOD_NTSC 8
`define VP_CPU_PERIOD_PAL  12

// System clocks per VDC enable
`define VP_VDC_PERIOD_NTSC 6
`define VP_VDC_PERIOD_PAL  10
`define VP_EN_CW           4    // Enable counter width, holds largest period

// Image store, 16 KB
`define VP_ROM_AW          14
`define VP_ROM_DEPTH       (1 << `VP_ROM_AW)
`define VP_CART_AW         12   // Console cartridge bus

// Keyboard matrix consumer grants this many after reset
`define VP_KEY_CREDITS     2

`endif

/* source/vp_pkg.sv */
//////////////////////////////
// Common types for the machine glue core
//////////////////////////////
`default_nettype none

package vp_pkg;

	// Video standard, picks periods and palette
	typedef enum logic {
		STD_NTSC = 1'b0,
		STD_PAL  = 1'b1
	} vp_standard_e;

	// Download index, only CART and XROM reach the image store
	typedef enum logic [1:0] {
		IMG_NONE = 2'd0,
		IMG_CART = 2'd1,   // Banked cartridge
		IMG_XROM = 2'd2,   // Linear XROM image
		IMG_FONT = 2'd3
	} vp_image_e;

	// Source of the pending key event
	typedef enum logic {
		SRC_PS2    = 1'b0,
		SRC_JOYPAD = 1'b1
	} vp_key_src_e;

	typedef logic [7:0]  byte_t;   // Image bytes, ASCII codes
	typedef logic [23:0] rgb_t;    // 8 bits per channel, red high

endpackage

`default_nettype wire

/* source/vp_clock_enables.sv */
//////////////////////////////
// CPU and VDC clock-enable pulses from clk_sys
// Periods follow the selected video standard
//////////////////////////////
`default_nettype none
`include "vp_config.svh"

module vp_clock_enables (
	input  logic                clk_sys,
	input  logic                reset,
	input  vp_pkg::vp_standard_e standard_i,
	output logic                cpu_en_o,
	output logic                vdc_en_o
);
	import vp_pkg::*;

	localparam int CW = `VP_EN_CW;

	localparam logic [CW-1:0] CPU_LAST_NTSC = CW'(`VP_CPU_PERIOD_NTSC - 1);
	localparam logic [CW-1:0] CPU_LAST_PAL  = CW'(`VP_CPU_PERIOD_PAL - 1);
	localparam logic [CW-1:0] VDC_LAST_NTSC = CW'(`VP_VDC_PERIOD_NTSC - 1);
	localparam logic [CW-1:0] VDC_LAST_PAL  = CW'(`VP_VDC_PERIOD_PAL - 1);

	vp_standard_e  std_q;      // Standard seen last cycle
	logic [CW-1:0] cpu_cnt;
	logic [CW-1:0] vdc_cnt;
	logic [CW-1:0] cpu_last;
	logic [CW-1:0] vdc_last;
	logic          std_change;

	assign cpu_last   = (standard_i == STD_PAL) ? CPU_LAST_PAL : CPU_LAST_NTSC;
	assign vdc_last   = (standard_i == STD_PAL) ? VDC_LAST_PAL : VDC_LAST_NTSC;
	assign std_change = (standard_i != std_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			std_q    <= STD_NTSC;
			cpu_cnt  <= '0;
			vdc_cnt  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			std_q <= standard_i;
			if (std_change) begin   // Restart both on a switch
				cpu_cnt  <= '0;
				vdc_cnt  <= '0;
				cpu_en_o <= 1'b0;
				vdc_en_o <= 1'b0;
			end else begin
				cpu_en_o <= (cpu_cnt == cpu_last);
				cpu_cnt  <= (cpu_cnt == cpu_last) ? '0 : cpu_cnt + 1'b1;
				vdc_en_o <= (vdc_cnt == vdc_last);
				vdc_cnt  <= (vdc_cnt == vdc_last) ? '0 : vdc_cnt + 1'b1;
			end
		end
	end

	// Enables are single-cycle strobes
	a_cpu_en_single: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o |=> !cpu_en_o);
	a_vdc_en_single: assert property (@(posedge clk_sys) disable iff (reset)
		vdc_en_o |=> !vdc_en_o);

endmodule

`default_nettype wire

/* source/vp_cart_store.sv */
//////////////////////////////
// Cartridge and XROM image store
// Filled by the download port, read by the console bus
//////////////////////////////
`default_nettype none
`include "vp_config.svh"

module vp_cart_store (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active_i,
	input  logic                    dl_wr_i,
	input  vp_pkg::vp_image_e       dl_index_i,
	input  logic [`VP_ROM_AW-1:0]   dl_addr_i,
	input  vp_pkg::byte_t           dl_data_i,
	input  logic [`VP_CART_AW-1:0]  cart_addr_i,
	input  logic                    bank0_i,
	input  logic                    bank1_i,
	input  logic                    cart_rd_i,
	output vp_pkg::byte_t           cart_data_o
);
	import vp_pkg::*;

	localparam int SZW = `VP_ROM_AW + 1;   // Must reach a full 16 KB count

	localparam logic [SZW-1:0] SIZE_4K  = SZW'(4096);
	localparam logic [SZW-1:0] SIZE_8K  = SZW'(8192);
	localparam logic [SZW-1:0] SIZE_16K = SZW'(16384);

	byte_t                 mem [`VP_ROM_DEPTH];
	vp_image_e             img_kind;
	logic                  dl_active_q;
	logic                  dl_rise;
	logic                  img_wr;
	logic [SZW-1:0]        img_size;
	logic [`VP_ROM_AW-1:0] rd_addr;

	assign dl_rise = dl_active_i & ~dl_active_q;
	assign img_wr  = dl_active_i & dl_wr_i &
	                 ((dl_index_i == IMG_CART) || (dl_index_i == IMG_XROM));

	//////////////////////////////
	// Download tracking
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			img_kind    <= IMG_NONE;
			img_size    <= '0;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_rise) begin
				img_kind <= dl_index_i;
				img_size <= SZW'(img_wr);   // First byte may come at once
			end else if (img_wr) begin
				img_size <= img_size + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Bank mapping, address bit 10 unused by carts
	always_comb begin
		if (img_kind == IMG_XROM) begin
			rd_addr = {2'b00, cart_addr_i};
		end else begin
			case (img_size)
				SIZE_4K:  rd_addr = {2'b00, bank0_i, cart_addr_i[11], cart_addr_i[9:0]};
				SIZE_8K:  rd_addr = {1'b0, bank1_i, bank0_i, cart_addr_i[11], cart_addr_i[9:0]};
				SIZE_16K: rd_addr = {bank1_i, bank0_i, cart_addr_i};
				default:  rd_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (img_wr)
			mem[dl_addr_i] <= dl_data_i;
		if (cart_rd_i)
			cart_data_o <= mem[rd_addr];   // One read per cycle
	end

	a_dl_addr_range: assert property (@(posedge clk_sys) disable iff (reset)
		img_wr |-> (int'(dl_addr_i) < `VP_ROM_DEPTH));

endmodule

`default_nettype wire

/* source/vp_key_translate.sv */
//////////////////////////////
// PS/2 and joypad keys to ASCII events
// Events go out under credit flow control
//////////////////////////////
`default_nettype none
`include "vp_config.svh"

module vp_key_translate (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic [10:0]   ps2_key_i,
	input  logic [9:0]    joy_numpad_i,
	input  logic          key_credit_i,
	output logic          key_valid_o,
	output vp_pkg::byte_t key_ascii_o,
	output logic          key_released_o
);
	import vp_pkg::*;

	localparam int CRW = $clog2(`VP_KEY_CREDITS + 1);
	localparam logic [CRW-1:0] CREDIT_MAX = CRW'(`VP_KEY_CREDITS);

	// Set-2 scancode, extended bit ignored
	function automatic byte_t ps2_to_ascii(input logic [7:0] code);
		case (code)
			8'h45: return "0";
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			8'h1F: return 8'h11;   // Left GUI, yes key
			8'h27: return 8'h12;   // Right GUI, no key
			8'h5A: return 8'd10;   // Enter
			8'h66: return 8'd8;    // Backspace
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed button wins
	function automatic byte_t joy_to_ascii(input logic [9:0] pad);
		byte_t code;
		code = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i])
				code = (i == 9) ? "0" : byte_t'(8'h31 + i);
		end
		return code;
	endfunction

	logic           ps2_tog_q;
	logic [9:0]     joy_q;
	logic           ps2_chg;
	logic           joy_chg;
	logic           accept;
	logic           ps2_hit_q;
	logic           joy_hit_q;
	byte_t          ps2_ascii_q;
	byte_t          joy_ascii_q;
	logic           ps2_rel_q;
	logic           joy_rel_q;
	logic           pend;
	vp_key_src_e    pend_src;
	logic           emit;
	logic [CRW-1:0] credits;

	assign ps2_chg = (ps2_key_i[10] != ps2_tog_q);
	assign joy_chg = (joy_numpad_i != joy_q);
	assign accept  = !pend && !ps2_hit_q && !joy_hit_q;   // One event in flight
	assign emit    = pend && (credits != '0);

	//////////////////////////////
	// Event detect
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2_tog_q <= 1'b0;
			joy_q     <= '0;
			ps2_hit_q <= 1'b0;
			joy_hit_q <= 1'b0;
		end else begin
			ps2_tog_q <= ps2_key_i[10];
			joy_q     <= joy_numpad_i;
			ps2_hit_q <= ps2_chg && accept;
			joy_hit_q <= joy_chg && accept;
		end
	end

	// Translated codes, frozen while an event is held
	always_ff @(posedge clk_sys) begin
		if (ps2_chg && accept) begin
			ps2_ascii_q <= ps2_to_ascii(ps2_key_i[7:0]);
			ps2_rel_q   <= ~ps2_key_i[9];
		end
		if (joy_chg && accept) begin
			joy_ascii_q <= joy_to_ascii(joy_numpad_i);
			joy_rel_q   <= (joy_numpad_i == '0);
		end
	end

	//////////////////////////////
	// Pending slot and credits
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pend        <= 1'b0;
			pend_src    <= SRC_PS2;
			credits     <= CREDIT_MAX;
			key_valid_o <= 1'b0;
		end else begin
			key_valid_o <= emit;
			if (ps2_hit_q || joy_hit_q) begin
				pend     <= 1'b1;
				pend_src <= ps2_hit_q ? SRC_PS2 : SRC_JOYPAD;   // PS/2 first
			end else if (emit) begin
				pend <= 1'b0;
			end
			credits <= credits + CRW'(key_credit_i) - CRW'(emit);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (emit) begin
			key_ascii_o    <= (pend_src == SRC_PS2) ? ps2_ascii_q : joy_ascii_q;
			key_released_o <= (pend_src == SRC_PS2) ? ps2_rel_q : joy_rel_q;
		end
	end

	// Consumer must not hand back more than it was granted
	a_credit_max: assert property (@(posedge clk_sys) disable iff (reset)
		credits <= CREDIT_MAX);

endmodule

`default_nettype wire

/* source/vp_palette.sv */
//////////////////////////////
// VDC colour code to 24-bit RGB
// Registered on each pixel enable
//////////////////////////////
`default_nettype none

module vp_palette (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  vp_pkg::vp_standard_e standard_i,
	input  logic                 pixel_en_i,
	input  logic [3:0]           vdc_color_i,   // {R, G, B, luma}
	output vp_pkg::rgb_t         rgb_o
);
	import vp_pkg::*;

	// Calibrated, odd entries are the luma variants
	localparam rgb_t NTSC_LUT [16] = '{
		24'h000000, 24'h676767,   // Black
		24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151,   // Red
		24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a,
		24'hcecece, 24'hffffff    // White
	};

	localparam rgb_t PAL_LUT [16] = '{
		24'h000000, 24'h494949,
		24'h0000b6, 24'h4949ff,   // Blue
		24'h00b601, 24'h49ff49,   // Green
		24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949,   // Red
		24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49,
		24'hb6b6b6, 24'hffffff
	};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= '0;
		end else if (pixel_en_i) begin
			rgb_o <= (standard_i == STD_PAL) ? PAL_LUT[vdc_color_i] : NTSC_LUT[vdc_color_i];
		end
	end

endmodule

`default_nettype wire

/* source/vp_system_top.sv */
//////////////////////////////
// Machine glue top level
// Enables, image store, key events and palette
//////////////////////////////
`default_nettype none
`include "vp_config.svh"

module vp_system_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  vp_pkg::vp_standard_e   standard_i,

	// Download port
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  vp_pkg::vp_image_e      dl_index_i,
	input  logic [`VP_ROM_AW-1:0]  dl_addr_i,
	input  vp_pkg::byte_t          dl_data_i,

	// Console cartridge bus
	input  logic [`VP_CART_AW-1:0] cart_addr_i,
	input  logic                   bank0_i,
	input  logic                   bank1_i,
	input  logic                   cart_rd_i,
	output vp_pkg::byte_t          cart_data_o,

	// Keys
	input  logic [10:0]            ps2_key_i,
	input  logic [9:0]             joy_numpad_i,
	input  logic                   key_credit_i,
	output logic                   key_valid_o,
	output vp_pkg::byte_t          key_ascii_o,
	output logic                   key_released_o,

	// Video
	input  logic [3:0]             vdc_color_i,
	output vp_pkg::rgb_t           rgb_o,
	output logic                   cpu_en_o,
	output logic                   vdc_en_o
);

	vp_clock_enables u_clock_enables (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.standard_i (standard_i),
		.cpu_en_o   (cpu_en_o),
		.vdc_en_o   (vdc_en_o)
	);

	vp_cart_store u_cart_store (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_index_i  (dl_index_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.cart_addr_i (cart_addr_i),
		.bank0_i     (bank0_i),
		.bank1_i     (bank1_i),
		.cart_rd_i   (cart_rd_i),
		.cart_data_o (cart_data_o)
	);

	vp_key_translate u_key_translate (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ps2_key_i      (ps2_key_i),
		.joy_numpad_i   (joy_numpad_i),
		.key_credit_i   (key_credit_i),
		.key_valid_o    (key_valid_o),
		.key_ascii_o    (key_ascii_o),
		.key_released_o (key_released_o)
	);

	// VDC enable doubles as the pixel clock enable
	vp_palette u_palette (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.standard_i  (standard_i),
		.pixel_en_i  (vdc_en_o),
		.vdc_color_i (vdc_color_i),
		.rgb_o       (rgb_o)
	);

endmodule

`default_nettype wire

/* dv/tb_vp_system.sv */
//////////////////////////////
// Testbench for the machine glue top level
// Stimulus for enables, image store, keys and palette
//////////////////////////////
`default_nettype none
`include "vp_config.svh"

module tb_vp_system;
	timeunit 1ns;
	timeprecision 100ps;
	import vp_pkg::*;

	localparam int CART_AW        = `VP_CART_AW;
	localparam int ROM_AW         = `VP_ROM_AW;
	localparam int KEY_CREDITS    = `VP_KEY_CREDITS;
	localparam int CART_BYTES     = 8192;
	localparam int XROM_BYTES     = 4096;
	localparam int TIMEOUT_CYCLES = CART_BYTES + XROM_BYTES + 1500;   // Downloads dominate

	// Reference gaps per standard
	localparam int CPU_GAP_NTSC = 8;
	localparam int CPU_GAP_PAL  = 12;
	localparam int VDC_GAP_NTSC = 6;
	localparam int VDC_GAP_PAL  = 10;

	logic                clk_sys;
	logic                reset;
	vp_standard_e        standard_i;
	logic                dl_active_i;
	logic                dl_wr_i;
	vp_image_e           dl_index_i;
	logic [ROM_AW-1:0]   dl_addr_i;
	byte_t               dl_data_i;
	logic [CART_AW-1:0]  cart_addr_i;
	logic                bank0_i;
	logic                bank1_i;
	logic                cart_rd_i;
	byte_t               cart_data_o;
	logic [10:0]         ps2_key_i;
	logic [9:0]          joy_numpad_i;
	logic                key_credit_i;
	logic                key_valid_o;
	byte_t               key_ascii_o;
	logic                key_released_o;
	logic [3:0]          vdc_color_i;
	rgb_t                rgb_o;
	logic                cpu_en_o;
	logic                vdc_en_o;

	int           seed;
	int           error_count = 0;
	int           cycle_count = 0;
	byte_t        model [1 << ROM_AW];   // Expected image contents
	logic         xrom_mode;
	logic [8:0]   exp_key;               // {released, ascii}
	vp_standard_e std_prev;
	int           cpu_gap;
	int           vdc_gap;
	logic         cpu_armed;
	logic         vdc_armed;
	int           cpu_expect;
	int           vdc_expect;
	logic         rd_check;
	byte_t        rd_expect;
	logic         pal_check;
	rgb_t         pal_expect;
	int           outstanding;           // Valids not yet paid back

	vp_system_top uut (.*);

	always #4 clk_sys = ~clk_sys;

	assign cpu_expect = (standard_i == STD_PAL) ? CPU_GAP_PAL : CPU_GAP_NTSC;
	assign vdc_expect = (standard_i == STD_PAL) ? VDC_GAP_PAL : VDC_GAP_NTSC;

	//////////////////////////////
	// Failure reporting
	task automatic stop_with_failure();
		error_count++;
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] expected,
	                               input logic [31:0] actual);
		$display("Fail %s: expected %0h, actual %0h", test, expected, actual);
		stop_with_failure();
	endtask

	// Address map of an 8 KB cart or a linear XROM
	function automatic int mapped_addr(input logic xrom, input logic [11:0] a,
	                                   input logic b0, input logic b1);
		if (xrom)
			return int'(a);
		return (int'(b1) << 12) | (int'(b0) << 11) | (int'(a[11]) << 10) | int'(a[9:0]);
	endfunction

	function automatic rgb_t palette_ref(input vp_standard_e std, input logic [3:0] idx);
		case (idx)
			4'd0:    return 24'h000000;
			4'd15:   return 24'hffffff;
			default: return (std == STD_PAL) ? 24'hb60000 : 24'h790000;   // Index 8
		endcase
	endfunction

	//////////////////////////////
	// Reference tracking
	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			std_prev    <= STD_NTSC;
			cpu_gap     <= 0;
			vdc_gap     <= 0;
			cpu_armed   <= 1'b0;
			vdc_armed   <= 1'b0;
			rd_check    <= 1'b0;
			rd_expect   <= '0;
			pal_check   <= 1'b0;
			pal_expect  <= '0;
			outstanding <= 0;
		end else begin
			std_prev <= standard_i;
			if (standard_i != std_prev) begin   // Counters restart so one gap is skipped
				cpu_armed <= 1'b0;
				vdc_armed <= 1'b0;
			end else begin
				cpu_armed <= cpu_armed | cpu_en_o;
				vdc_armed <= vdc_armed | vdc_en_o;
			end
			cpu_gap  <= cpu_en_o ? 1 : cpu_gap + 1;
			vdc_gap  <= vdc_en_o ? 1 : vdc_gap + 1;
			rd_check <= cart_rd_i;
			if (cart_rd_i)
				rd_expect <= model[mapped_addr(xrom_mode, cart_addr_i, bank0_i, bank1_i)];
			pal_check   <= vdc_en_o && (vdc_color_i inside {4'd0, 4'd8, 4'd15});
			pal_expect  <= palette_ref(standard_i, vdc_color_i);
			outstanding <= outstanding + int'(key_valid_o) - int'(key_credit_i);
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	//////////////////////////////
	// Checks
	a_cpu_gap: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_en_o && cpu_armed && standard_i == std_prev) |-> (cpu_gap == cpu_expect))
		else report_mismatch("cpu enable gap", 32'(cpu_expect), 32'($sampled(cpu_gap)));

	a_vdc_gap: assert property (@(posedge clk_sys) disable iff (reset)
		(vdc_en_o && vdc_armed && standard_i == std_prev) |-> (vdc_gap == vdc_expect))
		else report_mismatch("vdc enable gap", 32'(vdc_expect), 32'($sampled(vdc_gap)));

	a_cart_read: assert property (@(posedge clk_sys) disable iff (reset)
		rd_check |-> (cart_data_o == rd_expect))
		else report_mismatch("cart read", 32'($sampled(rd_expect)),
		                     32'($sampled(cart_data_o)));

	a_key_value: assert property (@(posedge clk_sys) disable iff (reset)
		key_valid_o |-> ({key_released_o, key_ascii_o} == exp_key))
		else report_mismatch("key event", 32'(exp_key),
		                     32'({$sampled(key_released_o), $sampled(key_ascii_o)}));

	a_key_credit: assert property (@(posedge clk_sys) disable iff (reset)
		key_valid_o |-> (outstanding < KEY_CREDITS))
		else begin
			$display("Key event sent with no credit left");
			stop_with_failure();
		end

	a_palette: assert property (@(posedge clk_sys) disable iff (reset)
		pal_check |-> (rgb_o == pal_expect))
		else report_mismatch("palette", 32'($sampled(pal_expect)), 32'($sampled(rgb_o)));

	//////////////////////////////
	// Stimulus
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic sweep_colours(input vp_standard_e std);
		standard_i  = std;
		vdc_color_i = 4'd0;
		repeat (25) step();
		vdc_color_i = 4'd8;
		repeat (25) step();
		vdc_color_i = 4'd15;
		repeat (25) step();
	endtask

	task automatic download(input vp_image_e kind, input int count);
		byte_t b;
		dl_index_i  = kind;
		dl_active_i = 1'b1;
		step();
		for (int a = 0; a < count; a++) begin
			b            = byte_t'($random(seed));
			model[a]     = b;
			dl_addr_i    = ROM_AW'(a);
			dl_data_i    = b;
			dl_wr_i      = 1'b1;
			step();
		end
		dl_wr_i     = 1'b0;
		dl_active_i = 1'b0;
		step();
	endtask

	task automatic read_burst(input logic [1:0] banks, input int count);
		for (int n = 0; n < count; n++) begin
			cart_addr_i = CART_AW'($random(seed));
			bank0_i     = banks[0];
			bank1_i     = banks[1];
			cart_rd_i   = 1'b1;   // Back to back reads
			step();
		end
		cart_rd_i = 1'b0;
		step();
		step();
	endtask

	task automatic return_credit();
		key_credit_i = 1'b1;
		step();
		key_credit_i = 1'b0;
	endtask

	task automatic take_key(input logic give_credit);
		do
			step();
		while (!key_valid_o);
		if (give_credit)
			return_credit();
	endtask

	task automatic ps2_event(input logic [7:0] code, input logic pressed,
	                         input byte_t ascii, input logic give_credit);
		exp_key   = {~pressed, ascii};
		ps2_key_i = {~ps2_key_i[10], pressed, 1'b0, code};
		take_key(give_credit);
	endtask

	task automatic joypad_event(input logic [9:0] pad, input byte_t ascii);
		exp_key      = {(pad == 10'd0), ascii};
		joy_numpad_i = pad;
		take_key(1'b1);
	endtask

	initial begin
		seed         = 32'hed80_baf4;
		clk_sys      = 1'b0;
		reset        = 1'b1;
		standard_i   = STD_NTSC;
		dl_active_i  = 1'b0;
		dl_wr_i      = 1'b0;
		dl_index_i   = IMG_NONE;
		dl_addr_i    = '0;
		dl_data_i    = '0;
		cart_addr_i  = '0;
		bank0_i      = 1'b0;
		bank1_i      = 1'b0;
		cart_rd_i    = 1'b0;
		ps2_key_i    = '0;
		joy_numpad_i = '0;
		key_credit_i = 1'b0;
		vdc_color_i  = 4'd0;
		xrom_mode    = 1'b0;
		exp_key      = '0;
		repeat (3) @(posedge clk_sys);
		#1 reset = 1'b0;

		sweep_colours(STD_NTSC);
		sweep_colours(STD_PAL);

		download(IMG_CART, CART_BYTES);
		for (int b = 0; b < 4; b++)
			read_burst(2'(b), 16);
		download(IMG_XROM, XROM_BYTES);
		xrom_mode = 1'b1;   // Bank lines must not matter now
		for (int b = 0; b < 4; b++)
			read_burst(2'(b), 16);

		// Set-2 codes with each event paid back at once
		ps2_event(8'h1C, 1'b1, "a", 1'b1);
		ps2_event(8'h2E, 1'b0, "5", 1'b1);
		ps2_event(8'h5A, 1'b1, 8'd10, 1'b1);
		ps2_event(8'h07, 1'b1, 8'h00, 1'b1);
		joypad_event(10'h088, "4");
		joypad_event(10'h000, 8'h00);

		// Third event has to wait with no credits back
		ps2_event(8'h1A, 1'b1, "z", 1'b0);
		ps2_event(8'h1A, 1'b1, "z", 1'b0);
		ps2_key_i = {~ps2_key_i[10], ps2_key_i[9:0]};
		repeat (30) step();
		return_credit();
		take_key(1'b0);
		return_credit();
		return_credit();
		repeat (4) step();

		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Errors were recorded during the run");
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/vp_pkg.sv
source/vp_clock_enables.sv
source/vp_cart_store.sv
source/vp_key_translate.sv
source/vp_palette.sv
source/vp_system_top.sv
dv/tb_vp_system.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_vp_system -f tb.f -o sim_vp && ./obj_dir/sim_vp > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "No pass result in log"; exit 1; }
echo "Simulation passed"
